// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= coreTb
LOG ?= sim.log
# extra build options, for example -GSEED=1234 to change the stimulus seed
SEED_ARGS ?=
OBJ_DIR ?= obj_dir
FILELIST := src.f

VFLAGS := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(SEED_ARGS) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* TEST FAILED \*\*\*' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) $(SEED_ARGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== coreTb.sv ====
module coreTb #(
	parameter int SEED = 32'hfc76
);

	localparam int N_INSTR = 200;
	localparam int CLK_PERIOD = 4;
	localparam int TIMEOUT = N_INSTR * 8 * CLK_PERIOD + 400;

	logic clk;
	logic rst;
	logic instrReq;
	logic instrAck;
	logic wbValid;
	logic halted;
	cpuPkg::wordT instr;
	cpuPkg::wordT wbData;
	cpuPkg::regIdxT wbReg;

	cpuPkg::wordT prog [N_INSTR];
	cpuPkg::wordT modelRegs [cpuPkg::NUM_REGS];
	cpuPkg::wordT modelMem [cpuPkg::DMEM_WORDS];
	cpuPkg::regIdxT expRegQ [$];
	cpuPkg::wordT expDataQ [$];
	integer seed;
	int wbSeen;

	pipeCore u_dut (
		.clk      (clk),
		.rst      (rst),
		.instr    (instr),
		.instrReq (instrReq),
		.instrAck (instrAck),
		.wbValid  (wbValid),
		.wbReg    (wbReg),
		.wbData   (wbData),
		.halted   (halted)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic stopOnError;
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkWb(string name, cpuPkg::regIdxT expReg, cpuPkg::wordT expData,
			cpuPkg::regIdxT actReg, cpuPkg::wordT actData);
		if (expReg !== actReg || expData !== actData) begin
			$display("Error: %s expected r%0d=%h actual r%0d=%h", name, expReg, expData,
				actReg, actData);
			stopOnError();
		end
	endtask

	task automatic checkHalt(string name, bit expHalt, logic actHalt);
		if (expHalt !== actHalt) begin
			$display("Error: %s expected halted=%b actual %b", name, expHalt, actHalt);
			stopOnError();
		end
	endtask

	task automatic checkFlag(string name, bit expFlag, logic actFlag);
		if (expFlag !== actFlag) begin
			$display("Error: %s expected %b actual %b", name, expFlag, actFlag);
			stopOnError();
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// program and reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic buildProgram;
		logic [31:0] opNum;
		logic [31:0] rnd;
		for (int i = 0; i < N_INSTR - 1; i++) begin
			opNum = $random(seed);
			opNum = opNum % 32'd15; // any opcode except halt, unused ones included.
			rnd = $random(seed);
			prog[i] = {opNum[3:0], rnd[11:0]};
		end
		prog[N_INSTR-1] = {cpuPkg::HALT, 12'h000};
	endtask

	function automatic int memAddr(cpuPkg::wordT sum);
		return {16'h0000, sum} % cpuPkg::DMEM_WORDS;
	endfunction

	task automatic runModel;
		cpuPkg::opT op;
		cpuPkg::wordT w;
		cpuPkg::wordT a;
		cpuPkg::wordT b;
		cpuPkg::wordT imm6;
		cpuPkg::wordT val;
		logic writes;
		for (int i = 0; i < N_INSTR; i++) begin
			w = prog[i];
			op = cpuPkg::opT'(w[15:12]);
			a = modelRegs[w[8:6]];
			b = modelRegs[w[5:3]];
			imm6 = {{10{w[5]}}, w[5:0]};
			val = '0;
			writes = 1'b1;
			case (op)
				cpuPkg::ADD: val = a + b;
				cpuPkg::SUB: val = a - b;
				cpuPkg::AND: val = a & b;
				cpuPkg::OR: val = a | b;
				cpuPkg::XOR: val = a ^ b;
				cpuPkg::SHL: val = a << b[3:0];
				cpuPkg::SHR: val = a >> b[3:0];
				cpuPkg::ADDI: val = a + imm6;
				cpuPkg::LDI: val = {8'h00, w[7:0]};
				cpuPkg::LD: val = modelMem[memAddr(a + imm6)];
				cpuPkg::ST: begin
					modelMem[memAddr(a + imm6)] = modelRegs[w[11:9]];
					writes = 1'b0;
				end
				default: writes = 1'b0;
			endcase
			if (writes) begin
				modelRegs[w[11:9]] = val;
				expRegQ.push_back(w[11:9]);
				expDataQ.push_back(val);
			end
		end
	endtask

	// One full four-phase exchange plus an idle cycle, so accepted
	// instructions land three edges apart.
	task automatic sendInstr(cpuPkg::wordT w);
		instr = w;
		instrReq = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!instrAck);
		instrReq = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (instrAck);
		@(posedge clk);
		#1;
	endtask

	always @(negedge clk) begin
		if (!rst && wbValid) begin
			if (expRegQ.size() == 0) begin
				$display("Error: writeback to r%0d appeared with nothing left to retire", wbReg);
				stopOnError();
			end else begin
				checkWb($sformatf("writeback %0d", wbSeen), expRegQ.pop_front(),
					expDataQ.pop_front(), wbReg, wbData);
				wbSeen++;
			end
		end
	end

	initial begin
		#(TIMEOUT);
		$display("Error: run timed out after %0d time units before the halt", TIMEOUT);
		stopOnError();
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		seed = SEED;
		wbSeen = 0;
		rst = 1'b1;
		instrReq = 1'b0;
		instr = cpuPkg::NOP_INSTR;
		for (int i = 0; i < cpuPkg::NUM_REGS; i++) begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < cpuPkg::DMEM_WORDS; i++) begin
			modelMem[i] = '0;
		end
		buildProgram();
		runModel();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (3) begin
			@(posedge clk);
			#1;
			checkFlag("reset instrAck", 1'b0, instrAck);
			checkFlag("reset wbValid", 1'b0, wbValid);
			checkHalt("reset halted", 1'b0, halted);
		end
		for (int i = 0; i < N_INSTR; i++) begin
			sendInstr(prog[i]);
		end
		while (!halted) begin
			@(posedge clk);
			#1;
		end
		if (expRegQ.size() != 0) begin
			$display("Error: halt expected 0 pending writebacks actual %0d", expRegQ.size());
			stopOnError();
		end
		// a request after the halt must be ignored for good.
		instr = {cpuPkg::LDI, 12'h2a5}; // an LDI would write back if it got in.
		instrReq = 1'b1;
		repeat (20) begin
			@(posedge clk);
			#1;
			checkFlag("instrAck after halt", 1'b0, instrAck);
			checkFlag("wbValid after halt", 1'b0, wbValid);
			checkHalt("halted is sticky", 1'b1, halted);
		end
		instrReq = 1'b0;
		$display("%0d writebacks compared", wbSeen);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== core_props.sv ====
module coreProps (
	input logic clk,
	input logic rst,
	input logic instrReq,
	input logic instrAck,
	input logic wbValid,
	input logic halted
);

	// ack only rises on an edge that saw the request.
	ackRise: assert property (@(posedge clk) disable iff (rst) $rose(instrAck) |-> $past(instrReq))
		else $error("instrAck rose without instrReq");

	ackFall: assert property (@(posedge clk) disable iff (rst) $fell(instrAck) |-> !$past(instrReq))
		else $error("instrAck fell while instrReq was still high");

	haltSticky: assert property (@(posedge clk) disable iff (rst) !$fell(halted))
		else $error("halted fell without reset");

	quietAfterHalt: assert property (@(posedge clk) disable iff (rst) halted |-> !wbValid)
		else $error("wbValid seen after halted");

endmodule

bind pipeCore coreProps u_props (
	.clk      (clk),
	.rst      (rst),
	.instrReq (instrReq),
	.instrAck (instrAck),
	.wbValid  (wbValid),
	.halted   (halted)
);

// ==== cpuIf.sv ====
interface decodeLink;
	logic valid;
	cpuPkg::ctrlT ctrl;
	logic isHalt;
	cpuPkg::regIdxT dest;
	cpuPkg::wordT opA;
	cpuPkg::wordT opB;
	cpuPkg::wordT storeData;

	modport src(output valid, ctrl, isHalt, dest, opA, opB, storeData);
	modport dst(input valid, ctrl, isHalt, dest, opA, opB, storeData);
endinterface

interface execLink;
	logic valid;
	cpuPkg::ctrlT ctrl;
	logic isHalt;
	cpuPkg::regIdxT dest;
	cpuPkg::wordT result;
	cpuPkg::wordT storeData;

	modport src(output valid, ctrl, isHalt, dest, result, storeData);
	modport dst(input valid, ctrl, isHalt, dest, result, storeData);
endinterface

// ==== cpuPkg.sv ====
package cpuPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths and basic types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int WORD_W = 16;
	localparam int REG_W = 3;
	localparam int NUM_REGS = 8;
	localparam int SHAMT_W = 4; // shifts use only the low bits of rt.

	typedef logic [WORD_W-1:0] wordT;
	typedef logic [REG_W-1:0] regIdxT;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction encoding
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [3:0] {
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		AND  = 4'd3,
		OR   = 4'd4,
		XOR  = 4'd5,
		SHL  = 4'd6,
		SHR  = 4'd7,
		ADDI = 4'd8,
		LDI  = 4'd9,
		LD   = 4'd10,
		ST   = 4'd11,
		HALT = 4'd15
	} opT;

	localparam int OP_MSB = 15;
	localparam int OP_LSB = 12;
	localparam int RD_MSB = 11;
	localparam int RD_LSB = 9;
	localparam int RS_MSB = 8;
	localparam int RS_LSB = 6;
	localparam int RT_MSB = 5;
	localparam int RT_LSB = 3;
	localparam int IMM6_MSB = 5; // sign-extended immediate.
	localparam int IMM8_MSB = 7; // zero-extended immediate of LDI.

	localparam wordT NOP_INSTR = '0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SHL = 3'd5,
		ALU_SHR = 3'd6
	} aluOpT;

	typedef struct packed {
		aluOpT aluOp;
		logic  useImm;
		logic  regWrite;
		logic  memWrite;
		logic  memToReg;
	} ctrlT;

	localparam ctrlT CTRL_NOP = '0;

	localparam int DMEM_WORDS = 16;

endpackage

// ==== decodeStage.sv ====
module decodeStage (
	input  logic            clk,
	input  logic            rst,
	input  logic            fetchValid,
	input  cpuPkg::wordT    fetchInstr,
	input  logic            wbValid,
	input  cpuPkg::regIdxT  wbReg,
	input  cpuPkg::wordT    wbData,
	decodeLink.src          link
);

	cpuPkg::opT op;
	cpuPkg::ctrlT ctrl;
	logic isHalt;
	logic isLdi;
	cpuPkg::regIdxT rdIdx;
	cpuPkg::regIdxT rsIdx;
	cpuPkg::regIdxT rtIdx;
	cpuPkg::regIdxT rdIdxB;
	cpuPkg::wordT rdDataA;
	cpuPkg::wordT rdDataB;
	cpuPkg::wordT imm6Ext;
	cpuPkg::wordT imm8Ext;
	cpuPkg::wordT opA;
	cpuPkg::wordT opB;

	assign op = fetchValid ? cpuPkg::opT'(fetchInstr[cpuPkg::OP_MSB:cpuPkg::OP_LSB]) : cpuPkg::NOP;
	assign rdIdx = fetchInstr[cpuPkg::RD_MSB:cpuPkg::RD_LSB];
	assign rsIdx = fetchInstr[cpuPkg::RS_MSB:cpuPkg::RS_LSB];
	assign rtIdx = fetchInstr[cpuPkg::RT_MSB:cpuPkg::RT_LSB];

	assign imm6Ext = {{(cpuPkg::WORD_W-cpuPkg::IMM6_MSB-1){fetchInstr[cpuPkg::IMM6_MSB]}},
		fetchInstr[cpuPkg::IMM6_MSB:0]};
	assign imm8Ext = {{(cpuPkg::WORD_W-cpuPkg::IMM8_MSB-1){1'b0}}, fetchInstr[cpuPkg::IMM8_MSB:0]};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// opcode decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		ctrl = cpuPkg::CTRL_NOP;
		isHalt = 1'b0;
		isLdi = 1'b0;
		case (op)
			cpuPkg::ADD: ctrl = '{cpuPkg::ALU_ADD, 1'b0, 1'b1, 1'b0, 1'b0};
			cpuPkg::SUB: ctrl = '{cpuPkg::ALU_SUB, 1'b0, 1'b1, 1'b0, 1'b0};
			cpuPkg::AND: ctrl = '{cpuPkg::ALU_AND, 1'b0, 1'b1, 1'b0, 1'b0};
			cpuPkg::OR:  ctrl = '{cpuPkg::ALU_OR, 1'b0, 1'b1, 1'b0, 1'b0};
			cpuPkg::XOR: ctrl = '{cpuPkg::ALU_XOR, 1'b0, 1'b1, 1'b0, 1'b0};
			cpuPkg::SHL: ctrl = '{cpuPkg::ALU_SHL, 1'b0, 1'b1, 1'b0, 1'b0};
			cpuPkg::SHR: ctrl = '{cpuPkg::ALU_SHR, 1'b0, 1'b1, 1'b0, 1'b0};
			cpuPkg::ADDI: ctrl = '{cpuPkg::ALU_ADD, 1'b1, 1'b1, 1'b0, 1'b0};
			cpuPkg::LDI: begin
				ctrl = '{cpuPkg::ALU_ADD, 1'b1, 1'b1, 1'b0, 1'b0};
				isLdi = 1'b1; // computed as zero plus the immediate.
			end
			cpuPkg::LD: ctrl = '{cpuPkg::ALU_ADD, 1'b1, 1'b1, 1'b0, 1'b1};
			cpuPkg::ST: ctrl = '{cpuPkg::ALU_ADD, 1'b1, 1'b0, 1'b1, 1'b0};
			cpuPkg::HALT: isHalt = 1'b1;
			default: ctrl = cpuPkg::CTRL_NOP; // unused opcodes fall through as NOP.
		endcase
	end

	// Port B reads rd for a store, so its value can travel on as store data.
	assign rdIdxB = (op == cpuPkg::ST) ? rdIdx : rtIdx;
	assign opA = isLdi ? '0 : rdDataA;
	assign opB = ctrl.useImm ? (isLdi ? imm8Ext : imm6Ext) : rdDataB;

	regFile u_regFile (
		.clk     (clk),
		.rst     (rst),
		.rdIdxA  (rsIdx),
		.rdIdxB  (rdIdxB),
		.wrEn    (wbValid),
		.wrIdx   (wbReg),
		.wrData  (wbData),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB)
	);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			link.valid <= 1'b0;
			link.ctrl <= cpuPkg::CTRL_NOP;
			link.isHalt <= 1'b0;
			link.dest <= '0;
			link.opA <= '0;
			link.opB <= '0;
			link.storeData <= '0;
		end else begin
			link.valid <= fetchValid;
			link.ctrl <= ctrl;
			link.isHalt <= isHalt;
			link.dest <= rdIdx;
			link.opA <= opA;
			link.opB <= opB;
			link.storeData <= rdDataB;
		end
	end

endmodule

// ==== executeStage.sv ====
module executeStage (
	input  logic clk,
	input  logic rst,
	decodeLink.dst link,
	execLink.src   out
);

	cpuPkg::wordT aluA;
	cpuPkg::wordT aluB;
	cpuPkg::wordT result;
	logic [cpuPkg::SHAMT_W-1:0] shamt;

	assign aluA = link.opA; // already zero for LDI.
	assign aluB = link.opB; // register or extended immediate.
	assign shamt = aluB[cpuPkg::SHAMT_W-1:0];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ALU
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (link.ctrl.aluOp)
			cpuPkg::ALU_ADD: result = aluA + aluB; // also the LD/ST address.
			cpuPkg::ALU_SUB: result = aluA - aluB;
			cpuPkg::ALU_AND: result = aluA & aluB;
			cpuPkg::ALU_OR:  result = aluA | aluB;
			cpuPkg::ALU_XOR: result = aluA ^ aluB;
			cpuPkg::ALU_SHL: result = aluA << shamt;
			cpuPkg::ALU_SHR: result = aluA >> shamt;
			default:         result = aluA + aluB;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// execute pipeline register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out.valid <= 1'b0;
			out.ctrl <= cpuPkg::CTRL_NOP;
			out.isHalt <= 1'b0;
			out.dest <= '0;
			out.result <= '0;
			out.storeData <= '0;
		end else begin
			out.valid <= link.valid;
			out.ctrl <= link.ctrl;
			out.isHalt <= link.valid && link.isHalt; // a halt flag needs a valid token behind it.
			out.dest <= link.dest;
			out.result <= result;
			out.storeData <= link.storeData;
		end
	end

endmodule

// ==== fetchStage.sv ====
module fetchStage (
	input  logic         clk,
	input  logic         rst,
	input  logic         instrReq,
	input  cpuPkg::wordT instr,
	output logic         instrAck,
	output logic         fetchValid,
	output cpuPkg::wordT fetchInstr
);

	logic frozen;
	logic capture;
	logic isHaltInstr;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// four-phase acknowledge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign capture = instrReq && !instrAck && !frozen;
	assign isHaltInstr = cpuPkg::opT'(instr[cpuPkg::OP_MSB:cpuPkg::OP_LSB]) == cpuPkg::HALT;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			instrAck <= 1'b0;
		end else if (capture) begin
			instrAck <= 1'b1; // ack rises on the capturing edge.
		end else if (!instrReq) begin
			instrAck <= 1'b0; // source has withdrawn its request.
		end
	end

	// Once a halt is taken nothing more enters the pipe until reset.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			frozen <= 1'b0;
		end else if (capture && isHaltInstr) begin
			frozen <= 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fetchValid <= 1'b0;
			fetchInstr <= cpuPkg::NOP_INSTR;
		end else if (capture) begin
			fetchValid <= 1'b1;
			fetchInstr <= instr;
		end else begin
			fetchValid <= 1'b0; // a bubble between accepted instructions.
			fetchInstr <= cpuPkg::NOP_INSTR;
		end
	end

endmodule

// ==== memStage.sv ====
module memStage #(
	parameter int DMEM_WORDS = cpuPkg::DMEM_WORDS
) (
	input  logic           clk,
	input  logic           rst,
	execLink.dst           link,
	output logic           wbValid,
	output cpuPkg::regIdxT wbReg,
	output cpuPkg::wordT   wbData,
	output logic           halted
);

	localparam int ADDR_W = $clog2(DMEM_WORDS);

	cpuPkg::wordT dmem [DMEM_WORDS];
	logic [ADDR_W-1:0] addr;
	cpuPkg::wordT loadWord;

	assign addr = link.result[ADDR_W-1:0]; // wraps modulo the memory depth.
	assign loadWord = dmem[addr];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data memory
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (link.valid && link.ctrl.memWrite) begin
			dmem[addr] <= link.storeData;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// writeback register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wbValid <= 1'b0;
			wbReg <= '0;
			wbData <= '0;
			halted <= 1'b0;
		end else begin
			wbValid <= link.valid && link.ctrl.regWrite;
			wbReg <= link.dest;
			wbData <= link.ctrl.memToReg ? loadWord : link.result;
			if (link.valid && link.isHalt) begin
				halted <= 1'b1; // sticky until reset.
			end
		end
	end

endmodule

// ==== pipeCore.sv ====
module pipeCore #(
	parameter int DMEM_WORDS = cpuPkg::DMEM_WORDS
) (
	input  logic           clk,
	input  logic           rst,
	input  cpuPkg::wordT   instr,
	input  logic           instrReq,
	output logic           instrAck,
	output logic           wbValid,
	output cpuPkg::regIdxT wbReg,
	output cpuPkg::wordT   wbData,
	output logic           halted
);

	logic fetchValid;
	cpuPkg::wordT fetchInstr;

	decodeLink decToExe ();
	execLink exeToMem ();

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pipeline stages
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	fetchStage u_fetch (
		.clk        (clk),
		.rst        (rst),
		.instrReq   (instrReq),
		.instr      (instr),
		.instrAck   (instrAck),
		.fetchValid (fetchValid),
		.fetchInstr (fetchInstr)
	);

	// The writeback outputs loop back here to the register file write port.
	decodeStage u_decode (
		.clk        (clk),
		.rst        (rst),
		.fetchValid (fetchValid),
		.fetchInstr (fetchInstr),
		.wbValid    (wbValid),
		.wbReg      (wbReg),
		.wbData     (wbData),
		.link       (decToExe.src)
	);

	executeStage u_execute (
		.clk  (clk),
		.rst  (rst),
		.link (decToExe.dst),
		.out  (exeToMem.src)
	);

	memStage #(
		.DMEM_WORDS (DMEM_WORDS)
	) u_mem (
		.clk     (clk),
		.rst     (rst),
		.link    (exeToMem.dst),
		.wbValid (wbValid),
		.wbReg   (wbReg),
		.wbData  (wbData),
		.halted  (halted)
	);

endmodule

// ==== regFile.sv ====
module regFile (
	input  logic           clk,
	input  logic           rst,
	input  cpuPkg::regIdxT rdIdxA,
	input  cpuPkg::regIdxT rdIdxB,
	input  logic           wrEn,
	input  cpuPkg::regIdxT wrIdx,
	input  cpuPkg::wordT   wrData,
	output cpuPkg::wordT   rdDataA,
	output cpuPkg::wordT   rdDataB
);

	cpuPkg::wordT regs [cpuPkg::NUM_REGS];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < cpuPkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrIdx] <= wrData;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read ports with write-through
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// A read in the cycle of the write sees the value about to land,
	// which covers the only hazard the spaced handshake leaves open.
	assign rdDataA = (wrEn && wrIdx == rdIdxA) ? wrData : regs[rdIdxA];
	assign rdDataB = (wrEn && wrIdx == rdIdxB) ? wrData : regs[rdIdxB];

endmodule

// ==== src.f ====
cpuPkg.sv
cpuIf.sv
fetchStage.sv
regFile.sv
decodeStage.sv
executeStage.sv
memStage.sv
pipeCore.sv
core_props.sv
coreTb.sv
